/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module execute_tb -Mdir obj_dir -o execute_tb
	./obj_dir/execute_tb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
verilog/exec_pkg.sv
verilog/int_alu.sv
verilog/csr_file.sv
verilog/iter_divider.sv
verilog/pipe_multiplier.sv
verilog/load_align.sv
verilog/data_ram.sv
verilog/execute_stage.sv
verilog/execute_top.sv
testbench/execute_tb.sv

/* testbench/execute_tb.sv */
module execute_tb import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [3:0][11:0] CSR_LIST = {CSR_MCAUSE, CSR_MEPC, CSR_MTVEC, CSR_MSCRATCH};

  logic        clk, rst, in_valid, in_nop;
  logic [31:0] pc, npc, imm, rdata1, rdata2, address;
  logic [4:0]  waddr;
  logic [11:0] caddr;
  logic        rden1, rden2, lui, auipc, jal, jalr;
  logic        load, store, csregister, division, multiplication;
  alu_op_t     alu_op;
  lsu_op_t     lsu_op;
  csr_op_t     csr_op;
  div_op_t     div_op;
  mul_op_t     mul_op;
  logic [3:0]  byteenable;
  logic        stall_in, clear_in;
  logic        wren, stall, illegal_csr;
  logic [4:0]  waddr_out;
  logic [31:0] wdata;

  int          errors = 0;
  logic [31:0] csr_model [4];
  logic [7:0]  ram_model [1024];

  execute_top #(.XLEN(32), .RAM_WORDS(256)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      abort_run($sformatf("CHECK FAILED at %0d ns: %s = 0x%h, expected 0x%h",
                          $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[4:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return $signed(a) >>> b[4:0];
      alu_or:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic [31:0] div_model(div_op_t op, logic [31:0] a, logic [31:0] b);
    logic               ovf;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] q;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    sa = a;
    sb = b;
    case (op)
      div_div: begin
        if (b == 32'd0) return 32'hffff_ffff;
        if (ovf) return a;
        q = sa / sb;
        return q;
      end
      div_divu: begin
        if (b == 32'd0) return 32'hffff_ffff;
        return a / b;
      end
      div_rem: begin
        if (b == 32'd0) return a;
        if (ovf) return 32'd0;
        q = sa % sb;
        return q;
      end
      default: begin
        if (b == 32'd0) return a;
        return a % b;
      end
    endcase
  endfunction

  // 64 bit wrap-around product gives the right bits for any signedness.
  function automatic logic [31:0] mul_model(mul_op_t op, logic [31:0] a, logic [31:0] b);
    logic [63:0] p;
    case (op)
      mul_mulh:   p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      mul_mulhsu: p = {{32{a[31]}}, a} * {32'd0, b};
      default:    p = {32'd0, a} * {32'd0, b};
    endcase
    return (op == mul_mul) ? p[31:0] : p[63:32];
  endfunction

  function automatic int csr_slot(logic [11:0] addr);
    case (addr)
      CSR_MSCRATCH: return 0;
      CSR_MTVEC:    return 1;
      CSR_MEPC:     return 2;
      default:      return 3;
    endcase
  endfunction

  task automatic drive_bubble();
    in_valid <= 1'b0;
    in_nop <= 1'b0;
    {rden1, rden2, lui, auipc, jal, jalr} <= '0;
    {load, store, csregister, division, multiplication} <= '0;
    csr_op <= csr_none;
    clear_in <= 1'b0;
  endtask

  task automatic reset_inputs();
    drive_bubble();
    rst <= 1'b0;
    stall_in <= 1'b0;
    {pc, npc, imm, rdata1, rdata2, address} <= '0;
    waddr <= '0;
    caddr <= '0;
    alu_op <= alu_add;
    lsu_op <= lsu_lw;
    div_op <= div_div;
    mul_op <= mul_mul;
    byteenable <= '0;
  endtask

  // the decode side goes idle once the instruction is sampled.
  task automatic capture_edge();
    @(posedge clk);
    drive_bubble();
  endtask

  task automatic await_write(input logic [4:0] rd, input logic [31:0] exp, input string what,
                             input int limit, output bit saw_stall);
    bit got;
    got = 0;
    saw_stall = 0;
    for (int i = 0; i < limit; i++) begin
      @(negedge clk);
      if (wren) begin
        got = 1;
        break;
      end
      if (stall) saw_stall = 1;
    end
    if (!got) abort_run($sformatf("timeout: no register write for %s", what));
    check("waddr_out", 32'(waddr_out), 32'(rd));
    check("wdata", wdata, exp);
    @(negedge clk);
    check("wren", 32'(wren), 32'd0); // one write only.
  endtask

  task automatic confirm_no_write(input string what);
    bit settled;
    settled = 0;
    for (int i = 0; i < 100; i++) begin
      @(negedge clk);
      check("wren", 32'(wren), 32'd0);
      if (!stall) begin
        settled = 1;
        break;
      end
    end
    if (!settled) abort_run($sformatf("timeout: stall stayed high after %s", what));
  endtask

  task automatic alu_case(input alu_op_t op, input logic use_rs2, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] iv, input logic [4:0] rd);
    logic [31:0] exp;
    bit st;
    exp = alu_model(op, a, use_rs2 ? b : iv);
    @(posedge clk);
    in_valid <= 1'b1;
    rden1 <= 1'b1;
    rden2 <= use_rs2;
    rdata1 <= a;
    rdata2 <= b;
    imm <= iv;
    alu_op <= op;
    waddr <= rd;
    capture_edge();
    await_write(rd, exp, "alu op", 1, st);
  endtask

  // kind 0 lui, 1 auipc, 2 jal, 3 jalr.
  task automatic upper_case(input int kind, input logic [4:0] rd);
    logic [31:0] iv, ad, nx, exp;
    bit st;
    iv = $urandom;
    ad = $urandom;
    nx = $urandom;
    exp = (kind == 0) ? iv : ((kind == 1) ? ad : nx);
    @(posedge clk);
    in_valid <= 1'b1;
    rden1 <= (kind == 3);
    imm <= iv;
    address <= ad;
    npc <= nx;
    waddr <= rd;
    lui <= (kind == 0);
    auipc <= (kind == 1);
    jal <= (kind == 2);
    jalr <= (kind == 3);
    capture_edge();
    if (rd == 5'd0) confirm_no_write("write to x0");
    else await_write(rd, exp, "upper or jump", 1, st);
  endtask

  task automatic csr_access(input csr_op_t op, input logic [11:0] addr, input logic use_reg,
                            input logic [31:0] src_v);
    logic [31:0] old, src;
    logic [4:0]  rd;
    int          k;
    bit          st;
    k = csr_slot(addr);
    old = csr_model[k];
    src = use_reg ? src_v : {27'd0, src_v[4:0]};
    rd = 5'($urandom_range(31, 1));
    case (op)
      csr_write: csr_model[k] = src;
      csr_set:   csr_model[k] = old | src;
      csr_clear: csr_model[k] = old & ~src;
      default:   csr_model[k] = old;
    endcase
    @(posedge clk);
    in_valid <= 1'b1;
    csregister <= 1'b1;
    csr_op <= op;
    caddr <= addr;
    rden1 <= use_reg;
    rdata1 <= src_v;
    imm <= src_v;
    waddr <= rd;
    capture_edge();
    await_write(rd, old, "csr access", 1, st);
  endtask

  task automatic divide_case(input div_op_t op, input logic [31:0] a, input logic [31:0] b);
    logic [4:0] rd;
    bit         st;
    rd = 5'($urandom_range(31, 1));
    @(posedge clk);
    in_valid <= 1'b1;
    division <= 1'b1;
    div_op <= op;
    {rden1, rden2} <= 2'b11;
    rdata1 <= a;
    rdata2 <= b;
    waddr <= rd;
    capture_edge();
    await_write(rd, div_model(op, a, b), "divide", 100, st);
    check("stall", 32'(st), 32'd1);
  endtask

  task automatic multiply_case(input mul_op_t op, input logic [31:0] a, input logic [31:0] b);
    logic [4:0] rd;
    bit         st;
    rd = 5'($urandom_range(31, 1));
    @(posedge clk);
    in_valid <= 1'b1;
    multiplication <= 1'b1;
    mul_op <= op;
    {rden1, rden2} <= 2'b11;
    rdata1 <= a;
    rdata2 <= b;
    waddr <= rd;
    capture_edge();
    await_write(rd, mul_model(op, a, b), "multiply", 20, st);
    check("stall", 32'(st), 32'd1);
  endtask

  // size is in bytes and data is right-aligned.
  task automatic store_data(input logic [31:0] addr, input logic [31:0] data, input int size);
    logic [3:0]  be;
    logic [31:0] lane;
    case (size)
      1:       be = 4'b0001 << addr[1:0];
      2:       be = addr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;
    endcase
    lane = data << (8 * addr[1:0]);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) ram_model[{addr[9:2], 2'(i)}] = lane[8*i +: 8];
    end
    @(posedge clk);
    in_valid <= 1'b1;
    store <= 1'b1;
    address <= addr;
    rdata2 <= lane;
    byteenable <= be;
    waddr <= 5'd5; // stores never write back.
    capture_edge();
    confirm_no_write("store");
  endtask

  task automatic load_data(input lsu_op_t op, input logic [31:0] addr);
    logic [3:0]  be;
    logic [31:0] exp;
    logic [7:0]  b0;
    logic [15:0] h;
    logic [4:0]  rd;
    bit          st;
    b0 = ram_model[addr[9:0]];
    h = {ram_model[{addr[9:1], 1'b1}], ram_model[{addr[9:1], 1'b0}]};
    rd = 5'($urandom_range(31, 1));
    case (op)
      lsu_lb, lsu_lbu: begin
        be = 4'b0001 << addr[1:0];
        exp = (op == lsu_lb) ? {{24{b0[7]}}, b0} : {24'd0, b0};
      end
      lsu_lh, lsu_lhu: begin
        be = addr[1] ? 4'b1100 : 4'b0011;
        exp = (op == lsu_lh) ? {{16{h[15]}}, h} : {16'd0, h};
      end
      default: begin
        be = 4'b1111;
        exp = {ram_model[{addr[9:2], 2'd3}], ram_model[{addr[9:2], 2'd2}],
               ram_model[{addr[9:2], 2'd1}], ram_model[{addr[9:2], 2'd0}]};
      end
    endcase
    @(posedge clk);
    in_valid <= 1'b1;
    load <= 1'b1;
    lsu_op <= op;
    address <= addr;
    byteenable <= be;
    waddr <= rd;
    capture_edge();
    await_write(rd, exp, "load", 10, st);
    check("stall", 32'(st), 32'd1);
  endtask

  task automatic alu_tests();
    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 4; j++) begin
        alu_case(alu_op_t'(i), j[0], $urandom, $urandom, $urandom, 5'($urandom_range(31, 1)));
      end
    end
  endtask

  task automatic upper_jump_tests();
    for (int k = 0; k < 4; k++) begin
      upper_case(k, 5'($urandom_range(31, 1)));
      upper_case(k, 5'd0);
    end
    alu_case(alu_add, 1'b1, $urandom, $urandom, 32'd0, 5'd1);
  endtask

  task automatic csr_tests();
    for (int k = 0; k < 4; k++) begin
      csr_access(csr_write, CSR_LIST[k], 1'b1, $urandom);
      csr_access(csr_set, CSR_LIST[k], 1'b0, $urandom);
      csr_access(csr_clear, CSR_LIST[k], 1'b1, $urandom);
      csr_access(csr_set, CSR_LIST[k], 1'b1, $urandom);
      csr_access(csr_clear, CSR_LIST[k], 1'b0, $urandom);
    end
    // an unknown address must leave every csr unchanged.
    @(posedge clk);
    in_valid <= 1'b1;
    csregister <= 1'b1;
    csr_op <= csr_write;
    caddr <= 12'h7c0;
    rden1 <= 1'b1;
    rdata1 <= $urandom;
    waddr <= 5'd9;
    capture_edge();
    @(negedge clk);
    check("illegal_csr", 32'(illegal_csr), 32'd1);
    check("wren", 32'(wren), 32'd0);
    for (int k = 0; k < 4; k++) csr_access(csr_set, CSR_LIST[k], 1'b0, 32'd0);
  endtask

  task automatic divmul_tests();
    for (int i = 0; i < 4; i++) begin
      divide_case(div_op_t'(i), $urandom, $urandom);
      divide_case(div_op_t'(i), $urandom, $urandom >> 24);
      divide_case(div_op_t'(i), $urandom, 32'hffff_fff0 | ($urandom & 32'hf));
      divide_case(div_op_t'(i), $urandom, 32'd0);
      divide_case(div_op_t'(i), 32'h8000_0000, 32'hffff_ffff);
      divide_case(div_op_t'(i), 32'hffff_fff9, 32'd2);
      multiply_case(mul_op_t'(i), $urandom, $urandom);
      multiply_case(mul_op_t'(i), 32'hffff_fffb, 32'd7);
      multiply_case(mul_op_t'(i), 32'h8000_0000, 32'hffff_ffff);
      multiply_case(mul_op_t'(i), 32'hffff_ffff, 32'hffff_ffff);
    end
  endtask

  task automatic memory_tests();
    store_data(32'h100, $urandom, 4);
    store_data(32'h104, 32'h8001_7f80, 4);
    store_data(32'h108, $urandom, 4);
    store_data(32'h104, 32'h0000_c3a5, 2);
    store_data(32'h10a, $urandom, 2);
    store_data(32'h109, 32'h0000_0091, 1);
    store_data(32'h10b, $urandom, 1);
    store_data(32'h102, 32'h0000_00ff, 1);
    for (int i = 0; i < 12; i++) begin
      load_data(lsu_lb, 32'h100 + i);
      load_data(lsu_lbu, 32'h100 + i);
      if (i % 2 == 0) begin
        load_data(lsu_lh, 32'h100 + i);
        load_data(lsu_lhu, 32'h100 + i);
      end
      if (i % 4 == 0) load_data(lsu_lw, 32'h100 + i);
    end
  endtask

  task automatic clear_stall_tests();
    logic [31:0] a, b;
    bit          st;
    for (int k = 0; k < 2; k++) begin
      @(posedge clk);
      in_valid <= 1'b1;
      {rden1, rden2} <= 2'b11;
      rdata1 <= $urandom;
      rdata2 <= $urandom;
      division <= (k == 1);
      waddr <= 5'd7;
      clear_in <= 1'b1;
      capture_edge();
      confirm_no_write("cleared instruction");
    end
    a = $urandom;
    b = $urandom;
    @(posedge clk);
    in_valid <= 1'b1;
    {rden1, rden2} <= 2'b11;
    rdata1 <= a;
    rdata2 <= b;
    alu_op <= alu_xor;
    waddr <= 5'd12;
    stall_in <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check("wren", 32'(wren), 32'd0);
    end
    @(posedge clk);
    stall_in <= 1'b0;
    @(negedge clk);
    check("wren", 32'(wren), 32'd0);
    capture_edge();
    await_write(5'd12, a ^ b, "held alu op", 1, st);
  endtask

  initial begin
    void'($urandom(32'h4104_015b));
    for (int k = 0; k < 4; k++) csr_model[k] = '0;
    reset_inputs();
    repeat (4) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    alu_tests();
    upper_jump_tests();
    csr_tests();
    divmul_tests();
    memory_tests();
    clear_stall_tests();
    if (errors == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run("errors were recorded during the run");
    end
  end

endmodule

/* verilog/csr_file.sv */
module csr_file import exec_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [11:0] caddr,
  input  logic [31:0] rdata1,
  input  logic [31:0] imm,
  input  logic        rden1,
  input  csr_op_t     csr_op,
  input  logic        csr_wren,
  output logic [31:0] cdata,
  output logic        illegal_csr
);

  logic [31:0] mscratch;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [31:0] src;
  logic [31:0] nval;
  logic        hit;

  always_comb begin
    hit = 1'b1;
    case (caddr)
      CSR_MSCRATCH: cdata = mscratch;
      CSR_MTVEC:    cdata = mtvec;
      CSR_MEPC:     cdata = mepc;
      CSR_MCAUSE:   cdata = mcause;
      default: begin
        cdata = '0;
        hit = 1'b0;
      end
    endcase
  end

  assign illegal_csr = (csr_op != csr_none) && !hit;
  assign src = rden1 ? rdata1 : {27'd0, imm[4:0]}; // uimm form.

  always_comb begin
    case (csr_op)
      csr_write: nval = src;
      csr_set:   nval = cdata | src;
      csr_clear: nval = cdata & ~src;
      default:   nval = cdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mscratch <= '0;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (csr_wren && hit) begin
      case (caddr)
        CSR_MSCRATCH: mscratch <= nval;
        CSR_MTVEC:    mtvec <= nval;
        CSR_MEPC:     mepc <= nval;
        default:      mcause <= nval;
      endcase
    end
  end

endmodule

/* verilog/data_ram.sv */
module data_ram import exec_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_req,
  input  logic        mem_we,
  input  logic [31:0] addr,
  input  logic [3:0]  byteenable,
  input  logic [31:0] wdata,
  output logic        mem_ready,
  output mem_word_t   mem_rdata
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [AW-1:0] idx;

  assign idx = addr[AW+1:2]; // word index.

  always_ff @(posedge clk) begin
    if (!rst) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= mem_req;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req) begin
      if (mem_we) begin
        for (int i = 0; i < 4; i++) begin
          if (byteenable[i]) begin
            mem[idx][8*i +: 8] <= wdata[8*i +: 8];
          end
        end
      end
      mem_rdata.word <= mem[idx];
    end
  end

endmodule

/* verilog/exec_pkg.sv */
package exec_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [2:0] {lsu_lb, lsu_lbu, lsu_lh, lsu_lhu, lsu_lw} lsu_op_t;

  typedef enum logic [1:0] {csr_none, csr_write, csr_set, csr_clear} csr_op_t;

  typedef enum logic [1:0] {div_div, div_divu, div_rem, div_remu} div_op_t;

  typedef enum logic [1:0] {mul_mul, mul_mulh, mul_mulhsu, mul_mulhu} mul_op_t;

  // implemented machine csrs.
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;

  // byte 0 is the low lane of the data word.
  typedef union packed {
    logic [31:0]      word;
    logic [3:0][7:0]  bytes;
  } mem_word_t;

endpackage

/* verilog/execute_stage.sv */
module execute_stage import exec_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  logic            in_nop,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] npc,
  input  logic [XLEN-1:0] imm,
  input  logic [XLEN-1:0] rdata1,
  input  logic [XLEN-1:0] rdata2,
  input  logic [XLEN-1:0] address,
  input  logic [4:0]      waddr,
  input  logic [11:0]     caddr,
  input  logic            rden1, rden2, lui, auipc, jal, jalr,
  input  logic            load, store, csregister, division, multiplication,
  input  alu_op_t         alu_op,
  input  lsu_op_t         lsu_op,
  input  csr_op_t         csr_op,
  input  div_op_t         div_op,
  input  mul_op_t         mul_op,
  input  logic [3:0]      byteenable,
  input  logic            stall_in,
  input  logic            clear_in,
  input  logic [XLEN-1:0] alu_res,
  input  logic [XLEN-1:0] cdata,
  input  logic            illegal_csr,
  input  logic            div_ready,
  input  logic [XLEN-1:0] div_result,
  input  logic            mul_ready,
  input  logic [XLEN-1:0] mul_result,
  input  logic            mem_ready,
  input  logic [XLEN-1:0] ldata,
  output logic [XLEN-1:0] alu_a,
  output logic [XLEN-1:0] alu_b,
  output alu_op_t         alu_op_out,
  output logic [XLEN-1:0] ex_rdata1, ex_rdata2, ex_imm, ex_address,
  output logic [11:0]     ex_caddr,
  output logic            ex_rden1,
  output csr_op_t         ex_csr_op,
  output div_op_t         ex_div_op,
  output mul_op_t         ex_mul_op,
  output lsu_op_t         ex_lsu_op,
  output logic [3:0]      ex_byteenable,
  output logic            csr_wren, div_enable, mul_enable, mem_req, mem_we,
  output logic            wren,
  output logic [4:0]      waddr_out,
  output logic [XLEN-1:0] wdata,
  output logic            stall
);

  logic            ex_valid, ex_kill, fresh, done;
  logic            ex_rden2, ex_lui, ex_auipc, ex_jal, ex_jalr;
  logic            ex_load, ex_store, ex_csr, ex_div, ex_mul;
  logic [XLEN-1:0] ex_pc, ex_npc;
  csr_op_t         ex_csr_op_q;
  logic            capture, live, multi, pending, unit_ready;
  logic [XLEN-1:0] unit_res;

  assign capture = !stall && !stall_in;
  assign live = ex_valid && !ex_kill;
  assign multi = ex_div || ex_mul || ex_load || ex_store;
  assign pending = live && multi && !done; // waiting on a unit.

  always_comb begin
    if (ex_div) begin
      unit_ready = div_ready;
      unit_res = div_result;
    end else if (ex_mul) begin
      unit_ready = mul_ready;
      unit_res = mul_result;
    end else begin
      unit_ready = mem_ready;
      unit_res = ldata;
    end
  end

  assign stall = pending && !unit_ready;

  // pc feeds the alu when there is no rs1.
  assign alu_a = ex_rden1 ? ex_rdata1 : ex_pc;
  assign alu_b = ex_rden2 ? ex_rdata2 : ex_imm;
  assign ex_csr_op = (live && ex_csr) ? ex_csr_op_q : csr_none;

  // enables fire once, in the first cycle after capture.
  assign div_enable = fresh && live && ex_div;
  assign mul_enable = fresh && live && ex_mul;
  assign mem_req = fresh && live && (ex_load || ex_store);
  assign mem_we = live && ex_store;
  assign csr_wren = fresh && live && ex_csr && !illegal_csr;

  assign wren = live && (waddr_out != 5'd0) && !illegal_csr &&
                (multi ? (pending && unit_ready && !ex_store) : fresh);

  always_comb begin
    if (pending && unit_ready) begin
      wdata = unit_res;
    end else if (ex_auipc) begin
      wdata = ex_address;
    end else if (ex_lui) begin
      wdata = ex_imm;
    end else if (ex_jal || ex_jalr) begin
      wdata = ex_npc;
    end else if (ex_csr) begin
      wdata = cdata; // old csr value.
    end else begin
      wdata = alu_res;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ex_valid <= 1'b0;
      ex_kill <= 1'b0;
      fresh <= 1'b0;
      done <= 1'b0;
    end else begin
      fresh <= capture;
      if (capture) begin
        ex_valid <= in_valid && !in_nop;
        ex_kill <= clear_in;
        done <= 1'b0;
      end else if (pending && unit_ready) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      ex_pc <= pc;
      ex_npc <= npc;
      ex_imm <= imm;
      ex_rdata1 <= rdata1;
      ex_rdata2 <= rdata2;
      ex_address <= address;
      waddr_out <= waddr;
      ex_caddr <= caddr;
      ex_rden1 <= rden1;
      ex_rden2 <= rden2;
      ex_lui <= lui;
      ex_auipc <= auipc;
      ex_jal <= jal;
      ex_jalr <= jalr;
      ex_load <= load;
      ex_store <= store;
      ex_csr <= csregister;
      ex_div <= division;
      ex_mul <= multiplication;
      alu_op_out <= alu_op;
      ex_lsu_op <= lsu_op;
      ex_csr_op_q <= csr_op;
      ex_div_op <= div_op;
      ex_mul_op <= mul_op;
      ex_byteenable <= byteenable;
    end
  end

endmodule

/* verilog/execute_top.sv */
module execute_top import exec_pkg::*; #(
  parameter int XLEN      = 32,
  parameter int RAM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  logic            in_nop,
  input  logic [XLEN-1:0] pc, npc, imm, rdata1, rdata2, address,
  input  logic [4:0]      waddr,
  input  logic [11:0]     caddr,
  input  logic            rden1, rden2, lui, auipc, jal, jalr,
  input  logic            load, store, csregister, division, multiplication,
  input  alu_op_t         alu_op,
  input  lsu_op_t         lsu_op,
  input  csr_op_t         csr_op,
  input  div_op_t         div_op,
  input  mul_op_t         mul_op,
  input  logic [3:0]      byteenable,
  input  logic            stall_in,
  input  logic            clear_in,
  output logic            wren,
  output logic [4:0]      waddr_out,
  output logic [XLEN-1:0] wdata,
  output logic            stall,
  output logic            illegal_csr
);

  logic [XLEN-1:0] alu_a, alu_b, alu_res, cdata, div_result, mul_result, ldata;
  logic [XLEN-1:0] ex_rdata1, ex_rdata2, ex_imm, ex_address;
  logic [11:0]     ex_caddr;
  logic [3:0]      ex_byteenable;
  logic            ex_rden1, csr_wren, div_enable, div_ready, mul_enable, mul_ready;
  logic            mem_req, mem_we, mem_ready;
  alu_op_t         alu_op_out;
  csr_op_t         ex_csr_op;
  div_op_t         ex_div_op;
  mul_op_t         ex_mul_op;
  lsu_op_t         ex_lsu_op;
  mem_word_t       mem_rdata;

  // stage port names match the nets here.
  execute_stage #(.XLEN(XLEN)) u_stage (.*);

  int_alu #(.XLEN(XLEN)) u_alu (
    .alu_op(alu_op_out), .a(alu_a), .b(alu_b), .res(alu_res)
  );

  csr_file u_csr (
    .clk(clk), .rst(rst), .caddr(ex_caddr), .rdata1(ex_rdata1), .imm(ex_imm),
    .rden1(ex_rden1), .csr_op(ex_csr_op), .csr_wren(csr_wren),
    .cdata(cdata), .illegal_csr(illegal_csr)
  );

  iter_divider u_div (
    .clk(clk), .rst(rst), .enable(div_enable), .div_op(ex_div_op),
    .dividend(ex_rdata1), .divisor(ex_rdata2), .ready(div_ready), .result(div_result)
  );

  pipe_multiplier u_mul (
    .clk(clk), .rst(rst), .enable(mul_enable), .mul_op(ex_mul_op),
    .a(ex_rdata1), .b(ex_rdata2), .ready(mul_ready), .result(mul_result)
  );

  load_align u_align (
    .lsu_op(ex_lsu_op), .byteenable(ex_byteenable), .mem_rdata(mem_rdata), .ldata(ldata)
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_we(mem_we), .addr(ex_address),
    .byteenable(ex_byteenable), .wdata(ex_rdata2), .mem_ready(mem_ready),
    .mem_rdata(mem_rdata)
  );

endmodule

/* verilog/int_alu.sv */
module int_alu import exec_pkg::*; #(
  parameter int XLEN = 32
) (
  input  alu_op_t         alu_op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  output logic [XLEN-1:0] res
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // rv32 shift amount.

  always_comb begin
    case (alu_op)
      alu_add:  res = a + b;
      alu_sub:  res = a - b;
      alu_sll:  res = a << shamt;
      alu_slt:  res = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      alu_sltu: res = {{(XLEN-1){1'b0}}, (a < b)};
      alu_xor:  res = a ^ b;
      alu_srl:  res = a >> shamt;
      alu_sra:  res = $signed(a) >>> shamt; // keeps the sign.
      alu_or:   res = a | b;
      alu_and:  res = a & b;
      default:  res = '0;
    endcase
  end

endmodule

/* verilog/iter_divider.sv */
module iter_divider import exec_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,
  input  div_op_t     div_op,
  input  logic [31:0] dividend,
  input  logic [31:0] divisor,
  output logic        ready,
  output logic [31:0] result
);

  logic        busy;
  logic [5:0]  count;
  logic [31:0] acc;
  logic [31:0] quo;
  logic [31:0] dvs;
  logic        neg_q;
  logic        neg_r;
  logic        want_rem;
  logic        a_neg;
  logic        b_neg;
  logic [32:0] shifted;
  logic [32:0] diff;

  assign a_neg = (div_op == div_div || div_op == div_rem) && dividend[31];
  assign b_neg = (div_op == div_div || div_op == div_rem) && divisor[31];
  assign shifted = {acc, quo[31]};
  assign diff = shifted - {1'b0, dvs}; // trial subtract.

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      count <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (enable) begin
        busy <= 1'b1;
        count <= 6'd32;
      end else if (busy && count == 6'd0) begin
        busy <= 1'b0;
        ready <= 1'b1;
      end else if (busy) begin
        count <= count - 6'd1;
      end
    end
  end

  // divide by zero keeps neg_q low, so the quotient stays all ones.
  always_ff @(posedge clk) begin
    if (enable) begin
      acc <= '0;
      quo <= a_neg ? -dividend : dividend;
      dvs <= b_neg ? -divisor : divisor;
      neg_q <= (a_neg ^ b_neg) && (divisor != 32'd0);
      neg_r <= a_neg;
      want_rem <= (div_op == div_rem) || (div_op == div_remu);
    end else if (busy && count != 6'd0) begin
      if (!diff[32]) begin
        acc <= diff[31:0];
        quo <= {quo[30:0], 1'b1};
      end else begin
        acc <= shifted[31:0]; // restore.
        quo <= {quo[30:0], 1'b0};
      end
    end else if (busy) begin
      result <= want_rem ? (neg_r ? -acc : acc) : (neg_q ? -quo : quo);
    end
  end

endmodule

/* verilog/load_align.sv */
module load_align import exec_pkg::*; (
  input  lsu_op_t     lsu_op,
  input  logic [3:0]  byteenable,
  input  mem_word_t   mem_rdata,
  output logic [31:0] ldata
);

  logic [7:0]  lbyte;
  logic [15:0] lhalf;

  always_comb begin
    casez (byteenable)
      4'b???1: lbyte = mem_rdata.bytes[0];
      4'b??10: lbyte = mem_rdata.bytes[1];
      4'b?100: lbyte = mem_rdata.bytes[2];
      default: lbyte = mem_rdata.bytes[3];
    endcase
  end

  assign lhalf = (byteenable[1:0] == 2'b11) ? {mem_rdata.bytes[1], mem_rdata.bytes[0]}
                                            : {mem_rdata.bytes[3], mem_rdata.bytes[2]};

  always_comb begin
    case (lsu_op)
      lsu_lb:  ldata = {{24{lbyte[7]}}, lbyte};
      lsu_lbu: ldata = {24'd0, lbyte};
      lsu_lh:  ldata = {{16{lhalf[15]}}, lhalf};
      lsu_lhu: ldata = {16'd0, lhalf};
      default: ldata = mem_rdata.bytes; // full word.
    endcase
  end

endmodule

/* verilog/pipe_multiplier.sv */
module pipe_multiplier import exec_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,
  input  mul_op_t     mul_op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic        ready,
  output logic [31:0] result
);

  logic               v1;
  logic               hi1;
  logic               a_sgn;
  logic               b_sgn;
  logic signed [32:0] a1;
  logic signed [32:0] b1;
  logic signed [65:0] prod;

  assign a_sgn = (mul_op == mul_mulh) || (mul_op == mul_mulhsu);
  assign b_sgn = (mul_op == mul_mulh);
  assign prod = a1 * b1;

  always_ff @(posedge clk) begin
    if (!rst) begin
      v1 <= 1'b0;
      ready <= 1'b0;
    end else begin
      v1 <= enable;
      ready <= v1;
    end
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      a1 <= {a_sgn & a[31], a}; // 33 bit operands.
      b1 <= {b_sgn & b[31], b};
      hi1 <= (mul_op != mul_mul);
    end
    if (v1) begin
      result <= hi1 ? prod[63:32] : prod[31:0];
    end
  end

endmodule
